// File: tb/pet_ctrl_testdata.txt
# Columns: operation, address, write data, expected value, all in hex
# W write (expect old value), R read, U unmapped (no ack), C controls {col_80, cpu_reset, cpu_ready}
# Reset state
C 00000 00 2
R 1E800 00 02
R 1E804 00 00
# Scratch registers in both banks
W 1E801 11 00
W 1E802 22 00
W 1E803 33 00
W 1E805 55 00
W 1E806 66 00
W 1E807 77 00
R 1E801 00 11
R 1E802 00 22
R 1E803 00 33
R 1E805 00 55
R 1E806 00 66
R 1E807 00 77
W 1E802 A5 22
R 1E802 00 A5
# CPU ready, reset released
W 1E800 01 02
C 00000 00 1
R 1E800 00 01
# Video 80 columns on and off
W 1E804 01 00
C 00000 00 5
W 1E804 00 01
C 00000 00 1
# Just outside the window
U 1E808 FF 00
U 1E7FF FF 00
R 1E800 00 01
R 1E801 00 11
R 1E802 00 A5
R 1E803 00 33
R 1E804 00 00
R 1E805 00 55
R 1E806 00 66
R 1E807 00 77
C 00000 00 1

// File: verilog.f
rtl/common_pkg.sv
rtl/wb_decode.sv
rtl/reg_bank.sv
rtl/wb_resp_merge.sv
rtl/pet_ctrl_regs.sv
tb/tb_pet_ctrl_regs.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the PET control register testbench with Verilator

LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert -f verilog.f \
    --top-module tb_pet_ctrl_regs -o sim_tb \
    && ./obj_dir/sim_tb > "$LOG" 2>&1 \
    || { echo "Build or simulation run failed"; exit 1; }

cat "$LOG"

grep -q "^ALL CHECKS PASSED$" "$LOG" \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }

// File: tb/tb_pet_ctrl_regs.sv
// Self-checking testbench for the PET control registers, replays bus operations from a data file
`timescale 1ns/1ns

module tb_pet_ctrl_regs;

    localparam int AW = common_pkg::WB_ADDR_WIDTH;
    localparam int DW = common_pkg::DATA_WIDTH;
    // 8 ns clock
    localparam int HALF_PERIOD = 4;
    // Acknowledge wait limits in cycles
    localparam int ACK_LIMIT   = 8;
    localparam int UNMAP_LIMIT = 4;

    logic          wb_clock_i;
    logic          rst_n_i;
    logic [AW-1:0] wb_addr_i;
    logic [DW-1:0] wb_data_i;
    logic          wb_we_i;
    logic          wb_cycle_i;
    logic          wb_strobe_i;
    logic [DW-1:0] wb_data_o;
    logic          wb_ack_o;
    logic          cpu_ready_o;
    logic          cpu_reset_o;
    logic          video_col_80_mode_o;

    int            checks;
    int            errors;
    // Control levels seen in the acknowledge cycle of the last mapped access
    logic [2:0]    ctrl_at_ack;
    logic          have_ack_snapshot;

    pet_ctrl_regs u_dut (
        .wb_clock_i          (wb_clock_i),
        .rst_n_i             (rst_n_i),
        .wb_addr_i           (wb_addr_i),
        .wb_data_i           (wb_data_i),
        .wb_we_i             (wb_we_i),
        .wb_cycle_i          (wb_cycle_i),
        .wb_strobe_i         (wb_strobe_i),
        .wb_data_o           (wb_data_o),
        .wb_ack_o            (wb_ack_o),
        .cpu_ready_o         (cpu_ready_o),
        .cpu_reset_o         (cpu_reset_o),
        .video_col_80_mode_o (video_col_80_mode_o)
    );

    initial begin
        wb_clock_i = 1'b0;
        forever #HALF_PERIOD wb_clock_i = ~wb_clock_i;
    end

    // Compare one value and log a mismatch
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
        end
    endtask

    // Single-cycle strobe, then wait for the acknowledge up to limit cycles
    task automatic bus_access(input logic [AW-1:0] addr, input logic we,
                              input logic [DW-1:0] wdata, input int limit,
                              output logic acked, output logic [DW-1:0] rdata,
                              output int cycles);
        // Request edge is the next rising edge
        @(negedge wb_clock_i);
        wb_addr_i   = addr;
        wb_data_i   = wdata;
        wb_we_i     = we;
        wb_cycle_i  = 1'b1;
        wb_strobe_i = 1'b1;
        @(negedge wb_clock_i);
        wb_cycle_i  = 1'b0;
        wb_strobe_i = 1'b0;
        wb_we_i     = 1'b0;
        // First sample is the cycle right after the request edge
        cycles = 1;
        while (!wb_ack_o && cycles < limit) begin
            @(negedge wb_clock_i);
            cycles++;
        end
        acked = wb_ack_o;
        rdata = wb_data_o;
        if (acked) begin
            ctrl_at_ack       = {video_col_80_mode_o, cpu_reset_o, cpu_ready_o};
            have_ack_snapshot = 1'b1;
            // Pulse gone one cycle later
            @(negedge wb_clock_i);
            check_value("wb_ack_o", 32'(wb_ack_o), 32'd0);
        end
    endtask

    // One line of the data file
    task automatic run_op(input logic [7:0] op, input logic [AW-1:0] addr,
                          input logic [DW-1:0] data, input logic [DW-1:0] expected);
        logic          acked;
        logic [DW-1:0] rdata;
        int            cycles;
        case (op)
            "W", "R": begin
                bus_access(addr, op == "W", data, ACK_LIMIT, acked, rdata, cycles);
                if (!acked) begin
                    errors++;
                    $display("Timeout: no acknowledge within %0d cycles for address 0x%0h",
                             ACK_LIMIT, addr);
                end else begin
                    check_value("wb_ack_o latency", 32'(cycles), 32'd1);
                    // Writes return the old value too
                    check_value("wb_data_o", 32'(rdata), 32'(expected));
                end
            end
            "U": begin
                bus_access(addr, 1'b1, data, UNMAP_LIMIT, acked, rdata, cycles);
                if (acked) begin
                    errors++;
                    $display("Unmapped address 0x%0h was acknowledged", addr);
                end
            end
            "C": begin
                check_value("control outputs",
                            32'({video_col_80_mode_o, cpu_reset_o, cpu_ready_o}),
                            32'(expected));
                // Levels must already hold in the cycle after the write edge
                if (have_ack_snapshot) begin
                    check_value("control outputs at ack", 32'(ctrl_at_ack), 32'(expected));
                end
            end
            default: begin
                errors++;
                $display("Unknown operation code 0x%0h in the test data", op);
            end
        endcase
    endtask

    initial begin
        int            fd;
        int            got;
        int            fields;
        string         line;
        logic [7:0]    op;
        logic [AW-1:0] addr;
        logic [DW-1:0] data;
        logic [DW-1:0] expected;
        rst_n_i           = 1'b0;
        wb_addr_i         = '0;
        wb_data_i         = '0;
        wb_we_i           = 1'b0;
        wb_cycle_i        = 1'b0;
        wb_strobe_i       = 1'b0;
        checks            = 0;
        errors            = 0;
        ctrl_at_ack       = '0;
        have_ack_snapshot = 1'b0;
        // Reset for three cycles
        repeat (3) @(negedge wb_clock_i);
        rst_n_i = 1'b1;
        @(negedge wb_clock_i);
        // Bus idle after reset
        check_value("wb_ack_o", 32'(wb_ack_o), 32'd0);
        check_value("wb_data_o", 32'(wb_data_o), 32'd0);
        fd = $fopen("tb/pet_ctrl_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the test data file");
        end else begin
            while (!$feof(fd)) begin
                got = $fgets(line, fd);
                // Skip blank and comment lines
                if (got > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%c %h %h %h", op, addr, data, expected);
                    if (fields == 4) begin
                        run_op(op, addr, data, expected);
                    end else begin
                        errors++;
                        $display("Malformed test data line: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/pet_ctrl_regs.sv
// PET control register block, Wishbone peripheral driving the CPU and video control levels
`timescale 1ns/1ns

module pet_ctrl_regs (
    input  logic                                 wb_clock_i,
    input  logic                                 rst_n_i,
    input  logic [common_pkg::WB_ADDR_WIDTH-1:0] wb_addr_i,
    input  logic [common_pkg::DATA_WIDTH-1:0]    wb_data_i,
    input  logic                                 wb_we_i,
    input  logic                                 wb_cycle_i,
    input  logic                                 wb_strobe_i,
    output logic [common_pkg::DATA_WIDTH-1:0]    wb_data_o,
    output logic                                 wb_ack_o,
    output logic                                 cpu_ready_o,
    output logic                                 cpu_reset_o,
    output logic                                 video_col_80_mode_o
);

    // Decoder outputs
    logic [common_pkg::BANK_COUNT-1:0]                             bank_sel;
    logic [common_pkg::REG_ADDR_WIDTH-1:0]                         reg_addr;
    // Per bank responses
    logic [common_pkg::BANK_COUNT-1:0]                             bank_ack;
    logic [common_pkg::BANK_COUNT-1:0][common_pkg::DATA_WIDTH-1:0] bank_data;
    logic [common_pkg::BANK_COUNT-1:0][common_pkg::DATA_WIDTH-1:0] bank_ctrl;
    // Control register writes, watched by the checks below
    logic                                                          sys_ctrl_wr;
    logic                                                          video_ctrl_wr;

    wb_decode u_decode (
        .wb_addr_i  (wb_addr_i),
        .bank_sel_o (bank_sel),
        .reg_addr_o (reg_addr)
    );

    for (genvar k = 0; k < common_pkg::BANK_COUNT; k++) begin : g_bank
        reg_bank u_bank (
            .wb_clock_i    (wb_clock_i),
            .rst_n_i       (rst_n_i),
            .reset_value_i (common_pkg::BANK_RESET_VALUE[k]),
            .bank_sel_i    (bank_sel[k]),
            .reg_addr_i    (reg_addr),
            .wb_data_i     (wb_data_i),
            .wb_we_i       (wb_we_i),
            .wb_cycle_i    (wb_cycle_i),
            .wb_strobe_i   (wb_strobe_i),
            .wb_data_o     (bank_data[k]),
            .wb_ack_o      (bank_ack[k]),
            .ctrl_word_o   (bank_ctrl[k])
        );
    end

    wb_resp_merge u_merge (
        .bank_ack_i          (bank_ack),
        .bank_data_i         (bank_data),
        .bank_ctrl_i         (bank_ctrl),
        .wb_clock_i          (wb_clock_i),
        .wb_ack_o            (wb_ack_o),
        .wb_data_o           (wb_data_o),
        .cpu_ready_o         (cpu_ready_o),
        .cpu_reset_o         (cpu_reset_o),
        .video_col_80_mode_o (video_col_80_mode_o)
    );

    assign sys_ctrl_wr = wb_cycle_i && wb_strobe_i && wb_we_i &&
                         bank_sel[common_pkg::BANK_SYS] && (reg_addr == common_pkg::REG_CTRL);
    assign video_ctrl_wr = wb_cycle_i && wb_strobe_i && wb_we_i &&
                           bank_sel[common_pkg::BANK_VIDEO] && (reg_addr == common_pkg::REG_CTRL);

    // Decoder picks at most one bank
    a_bank_sel_onehot : assert property (
        @(posedge wb_clock_i) disable iff (!rst_n_i)
        $onehot0(bank_sel)
    );

    // Written CPU bits reach the pins in the next cycle
    a_cpu_ctrl_write : assert property (
        @(posedge wb_clock_i) disable iff (!rst_n_i)
        sys_ctrl_wr |=>
            (cpu_ready_o == $past(wb_data_i[common_pkg::REG_CPU_READY_BIT])) &&
            (cpu_reset_o == $past(wb_data_i[common_pkg::REG_CPU_RESET_BIT]))
    );

    // Same for the column mode bit
    a_video_ctrl_write : assert property (
        @(posedge wb_clock_i) disable iff (!rst_n_i)
        video_ctrl_wr |=>
            (video_col_80_mode_o == $past(wb_data_i[common_pkg::REG_VIDEO_COL_80_BIT]))
    );

endmodule

// File: rtl/wb_resp_merge.sv
// Response merger, combines bank acknowledges and read data and decodes the control outputs
`timescale 1ns/1ns

module wb_resp_merge (
    input  logic [common_pkg::BANK_COUNT-1:0]                             bank_ack_i,
    input  logic [common_pkg::BANK_COUNT-1:0][common_pkg::DATA_WIDTH-1:0] bank_data_i,
    input  logic [common_pkg::BANK_COUNT-1:0][common_pkg::DATA_WIDTH-1:0] bank_ctrl_i,
    input  logic                                                          wb_clock_i,
    output logic                                                          wb_ack_o,
    output logic [common_pkg::DATA_WIDTH-1:0]                             wb_data_o,
    output logic                                                          cpu_ready_o,
    output logic                                                          cpu_reset_o,
    output logic                                                          video_col_80_mode_o
);

    // Control words seen through their bank views
    common_pkg::ctrl_word_u sys_ctrl;
    common_pkg::ctrl_word_u video_ctrl;

    // Any bank acknowledging acknowledges the bus
    assign wb_ack_o = |bank_ack_i;

    // Read data of the acknowledging bank
    // Zero while nobody acknowledges
    always_comb begin
        wb_data_o = '0;
        for (int k = 0; k < common_pkg::BANK_COUNT; k++) begin
            if (bank_ack_i[k]) begin
                wb_data_o = bank_data_i[k];
            end
        end
    end

    // Same byte layout, decoded two ways
    assign sys_ctrl   = bank_ctrl_i[common_pkg::BANK_SYS];
    assign video_ctrl = bank_ctrl_i[common_pkg::BANK_VIDEO];

    // CPU lines from the system bank
    assign cpu_ready_o = sys_ctrl.cpu.ready;
    assign cpu_reset_o = sys_ctrl.cpu.reset;

    // Column mode from the video bank
    assign video_col_80_mode_o = video_ctrl.video.col_80;

    // Banks never answer together
    a_single_bank_ack : assert property (
        @(posedge wb_clock_i)
        $onehot0(bank_ack_i)
    );

endmodule

// File: rtl/reg_bank.sv
// Register bank of four bytes with Wishbone read and write and an exported control word
`timescale 1ns/1ns

module reg_bank (
    input  logic                                  wb_clock_i,
    input  logic                                  rst_n_i,
    input  logic [common_pkg::DATA_WIDTH-1:0]     reset_value_i,
    input  logic                                  bank_sel_i,
    input  logic [common_pkg::REG_ADDR_WIDTH-1:0] reg_addr_i,
    input  logic [common_pkg::DATA_WIDTH-1:0]     wb_data_i,
    input  logic                                  wb_we_i,
    input  logic                                  wb_cycle_i,
    input  logic                                  wb_strobe_i,
    output logic [common_pkg::DATA_WIDTH-1:0]     wb_data_o,
    output logic                                  wb_ack_o,
    output logic [common_pkg::DATA_WIDTH-1:0]     ctrl_word_o
);

    // Register storage
    logic [common_pkg::DATA_WIDTH-1:0] regs [2**common_pkg::REG_ADDR_WIDTH];
    // Qualified request for this bank
    logic                              req;

    assign req = bank_sel_i && wb_cycle_i && wb_strobe_i;

    // Register contents and acknowledge
    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
            for (int i = 0; i < 2**common_pkg::REG_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
            // Control register gets the bank specific power-on value
            regs[common_pkg::REG_CTRL] <= reset_value_i;
        end else begin
            // One cycle pulse per request edge
            wb_ack_o <= req;
            if (req && wb_we_i) begin
                regs[reg_addr_i] <= wb_data_i;
            end
        end
    end

    // Read data captures the value before any write at the same edge
    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_data_o <= '0;
        end else if (req) begin
            wb_data_o <= regs[reg_addr_i];
        end
    end

    // Control word straight from register 0
    assign ctrl_word_o = regs[common_pkg::REG_CTRL];

    // Acknowledge only follows a request seen at the previous edge
    a_ack_follows_req : assert property (
        @(posedge wb_clock_i) disable iff (!rst_n_i)
        wb_ack_o |-> $past(req)
    );

endmodule

// File: rtl/wb_decode.sv
// Wishbone address decoder, maps the register window to a one-hot bank select and register index
`timescale 1ns/1ns

module wb_decode (
    input  logic [common_pkg::WB_ADDR_WIDTH-1:0]  wb_addr_i,
    output logic [common_pkg::BANK_COUNT-1:0]     bank_sel_o,
    output logic [common_pkg::REG_ADDR_WIDTH-1:0] reg_addr_o
);

    // Address falls inside the eight byte window
    logic                                  window_hit;
    // Bank index field of the address
    logic [common_pkg::BANK_SEL_WIDTH-1:0] bank_idx;

    // Compare everything above the bank and register fields
    assign window_hit =
        (wb_addr_i >> (common_pkg::REG_ADDR_WIDTH + common_pkg::BANK_SEL_WIDTH)) ==
        (common_pkg::WB_REG_BASE >> (common_pkg::REG_ADDR_WIDTH + common_pkg::BANK_SEL_WIDTH));

    // Bank field sits just above the register index
    assign bank_idx = wb_addr_i[common_pkg::REG_ADDR_WIDTH +: common_pkg::BANK_SEL_WIDTH];

    // Register index passes straight through
    assign reg_addr_o = wb_addr_i[common_pkg::REG_ADDR_WIDTH-1:0];

    // One select per bank
    // All zero outside the window
    always_comb begin
        bank_sel_o = '0;
        for (int k = 0; k < common_pkg::BANK_COUNT; k++) begin
            if (window_hit && (bank_idx == common_pkg::BANK_SEL_WIDTH'(k))) begin
                bank_sel_o[k] = 1'b1;
            end
        end
    end

endmodule

// File: rtl/common_pkg.sv
// Shared bus widths, register map, reset values and control word layout for the PET control registers
package common_pkg;

    // Bus widths
    localparam int WB_ADDR_WIDTH  = 17;
    localparam int DATA_WIDTH     = 8;

    // Bank geometry, four registers per bank
    localparam int REG_ADDR_WIDTH = 2;
    localparam int BANK_COUNT     = 2;
    localparam int BANK_SEL_WIDTH = 1;

    // Eight byte window in the 128 KB space
    // Bits [1:0] pick the register, bit [2] picks the bank
    localparam logic [WB_ADDR_WIDTH-1:0] WB_REG_BASE = 17'h1E800;

    // Bank indices
    localparam int BANK_SYS   = 0;
    localparam int BANK_VIDEO = 1;

    // Control register inside every bank
    localparam logic [REG_ADDR_WIDTH-1:0] REG_CTRL = 2'd0;

    // System control word bits
    localparam int REG_CPU_READY_BIT = 0;
    localparam int REG_CPU_RESET_BIT = 1;

    // Video control word bits
    localparam int REG_VIDEO_COL_80_BIT = 0;

    // Control register reset value per bank, entry 0 is the system bank
    // System: CPU held in reset and not ready
    // Video: 40 column mode
    localparam logic [BANK_COUNT-1:0][DATA_WIDTH-1:0] BANK_RESET_VALUE = {
        8'h00,
        8'h02
    };

    // CPU view of a control word
    typedef struct packed {
        logic [5:0] reserved;
        logic       reset;
        logic       ready;
    } cpu_ctrl_t;

    // Video view of a control word
    typedef struct packed {
        logic [6:0] reserved;
        logic       col_80;
    } video_ctrl_t;

    // One control byte, decoded per bank
    typedef union packed {
        logic [DATA_WIDTH-1:0] raw;
        cpu_ctrl_t             cpu;
        video_ctrl_t           video;
    } ctrl_word_u;

endpackage
